/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= rv_core.f
TB_TOP    ?= tb_rv_core
RTL_TOP   ?= rv_core
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TB_TOP)
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* rv_core.f */
src/isa_pkg.sv
src/alu_pkg.sv
src/reg_file.sv
src/id_stage.sv
src/ex_stage.sv
src/rv_core.sv
testbench/tb_rv_core.sv

/* src/alu_pkg.sv */
package alu_pkg;

	localparam int WORD_W  = 32;
	localparam int SHAMT_W = 5;

	localparam logic [WORD_W-1:0] ZERO_WORD = '0;

	typedef enum logic [3:0] {
		EX_NOP_OP  = 4'd0,
		EX_ADD_OP  = 4'd1,
		EX_SUB_OP  = 4'd2,
		EX_SLT_OP  = 4'd3,
		EX_SLTU_OP = 4'd4,
		EX_AND_OP  = 4'd5,
		EX_OR_OP   = 4'd6,
		EX_XOR_OP  = 4'd7,
		EX_SLL_OP  = 4'd8,
		EX_SRL_OP  = 4'd9,
		EX_SRA_OP  = 4'd10
	} aluop_e;

	// Which ALU group drives the result
	typedef enum logic [1:0] {
		EX_RES_NONE  = 2'd0,
		EX_RES_LOGIC = 2'd1,
		EX_RES_SHIFT = 2'd2,
		EX_RES_ARITH = 2'd3
	} alusel_e;

endpackage

/* src/ex_stage.sv */
`timescale 1ns/10ps

module ex_stage (
	input  logic                           clk,
	input  logic                           rst,
	input  alu_pkg::aluop_e                aluop_i,
	input  alu_pkg::alusel_e               alusel_i,
	input  logic [alu_pkg::WORD_W-1:0]     op1_i,
	input  logic [alu_pkg::WORD_W-1:0]     op2_i,
	input  logic                           w_enable_i,
	input  logic [isa_pkg::REG_ADDR_W-1:0] w_addr_i,
	output logic                           ex_fwd_enable_o,
	output logic [isa_pkg::REG_ADDR_W-1:0] ex_fwd_addr_o,
	output logic [alu_pkg::WORD_W-1:0]     ex_fwd_data_o,
	output logic                           wb_enable_o,
	output logic [isa_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [alu_pkg::WORD_W-1:0]     wb_data_o
);

	logic [alu_pkg::WORD_W-1:0]  op2_mux;
	logic [alu_pkg::WORD_W-1:0]  sum_res;
	logic                        lt_res;
	logic [alu_pkg::SHAMT_W-1:0] shamt;
	logic [alu_pkg::WORD_W-1:0]  arith_res;
	logic [alu_pkg::WORD_W-1:0]  logic_res;
	logic [alu_pkg::WORD_W-1:0]  shift_res;
	logic [alu_pkg::WORD_W-1:0]  result;

	// Subtract as add of the two's complement
	assign op2_mux = (aluop_i == alu_pkg::EX_SUB_OP) ? (~op2_i + 1'b1) : op2_i;
	assign sum_res = op1_i + op2_mux;
	assign lt_res  = (aluop_i == alu_pkg::EX_SLT_OP) ? ($signed(op1_i) < $signed(op2_i)) :
		(op1_i < op2_i);
	assign shamt   = op2_i[alu_pkg::SHAMT_W-1:0];

	always_comb
	begin
		case (aluop_i)
			alu_pkg::EX_ADD_OP, alu_pkg::EX_SUB_OP:
				arith_res = sum_res;
			alu_pkg::EX_SLT_OP, alu_pkg::EX_SLTU_OP:
				arith_res = {{(alu_pkg::WORD_W-1){1'b0}}, lt_res};
			default:
				arith_res = alu_pkg::ZERO_WORD;
		endcase
	end

	always_comb
	begin
		case (aluop_i)
			alu_pkg::EX_AND_OP: logic_res = op1_i & op2_i;
			alu_pkg::EX_OR_OP:  logic_res = op1_i | op2_i;
			alu_pkg::EX_XOR_OP: logic_res = op1_i ^ op2_i;
			default:            logic_res = alu_pkg::ZERO_WORD;
		endcase
	end

	always_comb
	begin
		case (aluop_i)
			alu_pkg::EX_SLL_OP: shift_res = op1_i << shamt;
			alu_pkg::EX_SRL_OP: shift_res = op1_i >> shamt;
			// Arithmetic shift copies the sign bit in from the left
			alu_pkg::EX_SRA_OP: shift_res = $unsigned($signed(op1_i) >>> shamt);
			default:            shift_res = alu_pkg::ZERO_WORD;
		endcase
	end

	always_comb
	begin
		case (alusel_i)
			alu_pkg::EX_RES_ARITH: result = arith_res;
			alu_pkg::EX_RES_LOGIC: result = logic_res;
			alu_pkg::EX_RES_SHIFT: result = shift_res;
			default:               result = alu_pkg::ZERO_WORD;
		endcase
	end

	// Result offered to decode in the same cycle
	assign ex_fwd_enable_o = w_enable_i;
	assign ex_fwd_addr_o   = w_addr_i;
	assign ex_fwd_data_o   = result;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_enable_o <= 1'b0;
			wb_addr_o   <= '0;
			wb_data_o   <= alu_pkg::ZERO_WORD;
		end
		else
		begin
			wb_enable_o <= w_enable_i;
			wb_addr_o   <= w_addr_i;
			wb_data_o   <= result;
		end
	end

endmodule

/* src/id_stage.sv */
`timescale 1ns/10ps

module id_stage (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           instr_valid_i,
	input  logic [31:0]                    instr_i,
	output logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr_o,
	output logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr_o,
	input  logic [alu_pkg::WORD_W-1:0]     rs1_data_i,
	input  logic [alu_pkg::WORD_W-1:0]     rs2_data_i,
	input  logic                           ex_fwd_enable_i,
	input  logic [isa_pkg::REG_ADDR_W-1:0] ex_fwd_addr_i,
	input  logic [alu_pkg::WORD_W-1:0]     ex_fwd_data_i,
	input  logic                           wb_enable_i,
	input  logic [isa_pkg::REG_ADDR_W-1:0] wb_addr_i,
	input  logic [alu_pkg::WORD_W-1:0]     wb_data_i,
	output alu_pkg::aluop_e                aluop_o,
	output alu_pkg::alusel_e               alusel_o,
	output logic [alu_pkg::WORD_W-1:0]     op1_o,
	output logic [alu_pkg::WORD_W-1:0]     op2_o,
	output logic                           w_enable_o,
	output logic [isa_pkg::REG_ADDR_W-1:0] w_addr_o
);

	isa_pkg::instr_t            instr;
	logic                       is_op;
	logic                       is_imm;
	logic                       alt_r;
	logic                       alt_i;
	alu_pkg::aluop_e            dec_aluop;
	alu_pkg::alusel_e           dec_alusel;
	logic [alu_pkg::WORD_W-1:0] imm_op2;
	logic [alu_pkg::WORD_W-1:0] src1;
	logic [alu_pkg::WORD_W-1:0] src2;

	assign instr  = instr_i;
	assign is_op  = (instr.r_view.opcode == isa_pkg::OPC_OP);
	assign is_imm = (instr.i_view.opcode == isa_pkg::OPC_OP_IMM);
	assign alt_r  = (instr.r_view.funct7 == isa_pkg::F7_ALT);
	// SRAI carries the alternate marker in the upper immediate bits
	assign alt_i  = (instr.i_view.imm[11:5] == isa_pkg::F7_ALT);

	assign rs1_addr_o = instr.r_view.rs1;
	assign rs2_addr_o = instr.r_view.rs2;

	always_comb
	begin
		dec_aluop  = alu_pkg::EX_NOP_OP;
		dec_alusel = alu_pkg::EX_RES_NONE;
		if (is_op || is_imm)
		begin
			case (instr.r_view.funct3)
				isa_pkg::F3_ADD_SUB:
				begin
					dec_aluop  = (is_op && alt_r) ? alu_pkg::EX_SUB_OP : alu_pkg::EX_ADD_OP;
					dec_alusel = alu_pkg::EX_RES_ARITH;
				end
				isa_pkg::F3_SLT:
				begin
					dec_aluop  = alu_pkg::EX_SLT_OP;
					dec_alusel = alu_pkg::EX_RES_ARITH;
				end
				isa_pkg::F3_SLTU:
				begin
					dec_aluop  = alu_pkg::EX_SLTU_OP;
					dec_alusel = alu_pkg::EX_RES_ARITH;
				end
				isa_pkg::F3_XOR:
				begin
					dec_aluop  = alu_pkg::EX_XOR_OP;
					dec_alusel = alu_pkg::EX_RES_LOGIC;
				end
				isa_pkg::F3_OR:
				begin
					dec_aluop  = alu_pkg::EX_OR_OP;
					dec_alusel = alu_pkg::EX_RES_LOGIC;
				end
				isa_pkg::F3_AND:
				begin
					dec_aluop  = alu_pkg::EX_AND_OP;
					dec_alusel = alu_pkg::EX_RES_LOGIC;
				end
				isa_pkg::F3_SLL:
				begin
					dec_aluop  = alu_pkg::EX_SLL_OP;
					dec_alusel = alu_pkg::EX_RES_SHIFT;
				end
				default:
				begin
					dec_aluop  = (is_op ? alt_r : alt_i) ? alu_pkg::EX_SRA_OP : alu_pkg::EX_SRL_OP;
					dec_alusel = alu_pkg::EX_RES_SHIFT;
				end
			endcase
		end
	end

	// Immediate shifts take only the shamt field
	assign imm_op2 = (dec_alusel == alu_pkg::EX_RES_SHIFT) ?
		{{(alu_pkg::WORD_W-alu_pkg::SHAMT_W){1'b0}}, instr.i_view.imm[alu_pkg::SHAMT_W-1:0]} :
		{{(alu_pkg::WORD_W-12){instr.i_view.imm[11]}}, instr.i_view.imm};

	// Newest producer wins, x0 always reads from the file
	function automatic logic [alu_pkg::WORD_W-1:0] fwd_select(
		input logic [isa_pkg::REG_ADDR_W-1:0] addr,
		input logic [alu_pkg::WORD_W-1:0]     rf_data
	);
		if (addr == '0)
			return rf_data;
		if (ex_fwd_enable_i && ex_fwd_addr_i == addr)
			return ex_fwd_data_i;
		if (wb_enable_i && wb_addr_i == addr)
			return wb_data_i;
		return rf_data;
	endfunction

	assign src1 = fwd_select(instr.r_view.rs1, rs1_data_i);
	assign src2 = is_op ? fwd_select(instr.r_view.rs2, rs2_data_i) : imm_op2;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			aluop_o    <= alu_pkg::EX_NOP_OP;
			alusel_o   <= alu_pkg::EX_RES_NONE;
			op1_o      <= alu_pkg::ZERO_WORD;
			op2_o      <= alu_pkg::ZERO_WORD;
			w_enable_o <= 1'b0;
			w_addr_o   <= '0;
		end
		else
		begin
			aluop_o    <= dec_aluop;
			alusel_o   <= dec_alusel;
			op1_o      <= src1;
			op2_o      <= src2;
			w_enable_o <= instr_valid_i && (is_op || is_imm) && (instr.r_view.rd != '0);
			w_addr_o   <= instr.r_view.rd;
		end
	end

endmodule

/* src/isa_pkg.sv */
package isa_pkg;

	// Register address width for a 32-entry file
	localparam int REG_ADDR_W = 5;

	// Major opcodes handled by the core
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct3 encodings shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// Selects SUB and SRA/SRAI
	localparam logic [6:0] F7_ALT = 7'b0100000;

	typedef struct packed {
		logic [6:0]            funct7;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [REG_ADDR_W-1:0] rd;
		logic [6:0]            opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0]           imm;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [REG_ADDR_W-1:0] rd;
		logic [6:0]            opcode;
	} i_type_t;

	// Same 32 bits seen as either format
	typedef union packed {
		r_type_t r_view;
		i_type_t i_view;
	} instr_t;

endpackage

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file #(
	parameter int NUM_REGS = 32
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
	input  logic                           w_enable_i,
	input  logic [isa_pkg::REG_ADDR_W-1:0] w_addr_i,
	input  logic [alu_pkg::WORD_W-1:0]     w_data_i,
	output logic [alu_pkg::WORD_W-1:0]     rs1_data_o,
	output logic [alu_pkg::WORD_W-1:0]     rs2_data_o
);

	localparam int IDX_W = $clog2(NUM_REGS);

	logic [alu_pkg::WORD_W-1:0] regs [NUM_REGS];

	// x0 and anything past the end of the file are not real storage
	function automatic logic addr_ok(input logic [isa_pkg::REG_ADDR_W-1:0] addr);
		return (addr != '0) && (int'(addr) < NUM_REGS);
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= alu_pkg::ZERO_WORD;
			end
		end
		else if (w_enable_i && addr_ok(w_addr_i))
		begin
			regs[w_addr_i[IDX_W-1:0]] <= w_data_i;
		end
	end

	// Combinational reads
	assign rs1_data_o = addr_ok(rs1_addr_i) ? regs[rs1_addr_i[IDX_W-1:0]] : alu_pkg::ZERO_WORD;
	assign rs2_data_o = addr_ok(rs2_addr_i) ? regs[rs2_addr_i[IDX_W-1:0]] : alu_pkg::ZERO_WORD;

endmodule

/* src/rv_core.sv */
`timescale 1ns/10ps

module rv_core #(
	parameter int NUM_REGS = 32
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           instr_valid_i,
	input  logic [31:0]                    instr_i,
	output logic                           wb_enable_o,
	output logic [isa_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [alu_pkg::WORD_W-1:0]     wb_data_o
);

	logic [isa_pkg::REG_ADDR_W-1:0] rs1_addr;
	logic [isa_pkg::REG_ADDR_W-1:0] rs2_addr;
	logic [alu_pkg::WORD_W-1:0]     rs1_data;
	logic [alu_pkg::WORD_W-1:0]     rs2_data;

	// ID/EX register contents
	alu_pkg::aluop_e                aluop;
	alu_pkg::alusel_e               alusel;
	logic [alu_pkg::WORD_W-1:0]     op1;
	logic [alu_pkg::WORD_W-1:0]     op2;
	logic                           w_enable;
	logic [isa_pkg::REG_ADDR_W-1:0] w_addr;

	// EX result fed back for forwarding
	logic                           ex_fwd_enable;
	logic [isa_pkg::REG_ADDR_W-1:0] ex_fwd_addr;
	logic [alu_pkg::WORD_W-1:0]     ex_fwd_data;

	id_stage u_id_stage (
		.clk             (clk),
		.rst             (rst),
		.instr_valid_i   (instr_valid_i),
		.instr_i         (instr_i),
		.rs1_addr_o      (rs1_addr),
		.rs2_addr_o      (rs2_addr),
		.rs1_data_i      (rs1_data),
		.rs2_data_i      (rs2_data),
		.ex_fwd_enable_i (ex_fwd_enable),
		.ex_fwd_addr_i   (ex_fwd_addr),
		.ex_fwd_data_i   (ex_fwd_data),
		.wb_enable_i     (wb_enable_o),
		.wb_addr_i       (wb_addr_o),
		.wb_data_i       (wb_data_o),
		.aluop_o         (aluop),
		.alusel_o        (alusel),
		.op1_o           (op1),
		.op2_o           (op2),
		.w_enable_o      (w_enable),
		.w_addr_o        (w_addr)
	);

	ex_stage u_ex_stage (
		.clk             (clk),
		.rst             (rst),
		.aluop_i         (aluop),
		.alusel_i        (alusel),
		.op1_i           (op1),
		.op2_i           (op2),
		.w_enable_i      (w_enable),
		.w_addr_i        (w_addr),
		.ex_fwd_enable_o (ex_fwd_enable),
		.ex_fwd_addr_o   (ex_fwd_addr),
		.ex_fwd_data_o   (ex_fwd_data),
		.wb_enable_o     (wb_enable_o),
		.wb_addr_o       (wb_addr_o),
		.wb_data_o       (wb_data_o)
	);

	// Write port driven straight from EX/WB
	reg_file #(
		.NUM_REGS (NUM_REGS)
	) u_reg_file (
		.clk        (clk),
		.rst        (rst),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.w_enable_i (wb_enable_o),
		.w_addr_i   (wb_addr_o),
		.w_data_i   (wb_data_o),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

endmodule

/* testbench/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

	logic        clk;
	logic        rst;
	logic        instr_valid_i;
	logic [31:0] instr_i;
	logic        wb_enable_o;
	logic [4:0]  wb_addr_o;
	logic [31:0] wb_data_o;

	// Architectural register state, updated in program order
	logic [31:0] model [32];
	logic [31:0] lfsr_state;
	int          cyc;

	// Pending write-backs in issue order
	int          exp_cycle [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];

	rv_core #(
		.NUM_REGS (32)
	) dut (
		.clk           (clk),
		.rst           (rst),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.wb_enable_o   (wb_enable_o),
		.wb_addr_o     (wb_addr_o),
		.wb_data_o     (wb_data_o)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// RV32I result rules for OP and OP-IMM
	function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0] s;
		s = b[4:0];
		case (f3)
			isa_pkg::F3_ADD_SUB: return alt ? a - b : a + b;
			isa_pkg::F3_SLL:     return a << s;
			isa_pkg::F3_SLT:     return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, (a < b)};
			isa_pkg::F3_SLTU:    return {31'b0, (a < b)};
			isa_pkg::F3_XOR:     return a ^ b;
			isa_pkg::F3_OR:      return a | b;
			isa_pkg::F3_AND:     return a & b;
			default:
				return (alt && a[31]) ? ((a >> s) | ~(32'hffffffff >> s)) : (a >> s);
		endcase
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("FAIL at %0t ns: %s expected %h got %h", $time, what, expected, actual);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Advance to the next falling edge and compare any write-back
	task automatic tick();
		@(negedge clk);
		cyc++;
		if (wb_enable_o)
		begin
			if (exp_cycle.size() == 0)
			begin
				$display("A write-back to x%0d appeared with no instruction pending", wb_addr_o);
				$display("Checks failed");
				$fatal(1, "unexpected write-back");
			end
			else
			begin
				check(cyc, exp_cycle.pop_front(), "write-back cycle");
				check({27'b0, wb_addr_o}, exp_addr.pop_front(), "write-back address");
				check(wb_data_o, exp_data.pop_front(), "write-back data");
			end
		end
		else if (exp_cycle.size() > 0 && exp_cycle[0] <= cyc)
		begin
			$display("The write-back to x%0d did not appear on time", exp_addr[0]);
			$display("Checks failed");
			$fatal(1, "missing write-back");
		end
	endtask

	task automatic send(input logic [31:0] word, input int rd, input logic [31:0] res);
		instr_valid_i = 1'b1;
		instr_i       = word;
		if (rd != 0)
		begin
			model[rd] = res;
			exp_cycle.push_back(cyc + 2);
			exp_addr.push_back(rd);
			exp_data.push_back(res);
		end
		tick();
	endtask

	task automatic issue_r(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		logic [31:0] word;
		word = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], isa_pkg::OPC_OP};
		send(word, rd, ref_result(f3, f7 == isa_pkg::F7_ALT, model[rs1], model[rs2]));
	endtask

	task automatic issue_i(input logic [31:0] imm, input int rs1, input logic [2:0] f3,
		input int rd);
		logic [31:0] word;
		logic [31:0] b;
		logic        alt;
		word = {imm[11:0], rs1[4:0], f3, rd[4:0], isa_pkg::OPC_OP_IMM};
		b    = {{20{imm[11]}}, imm[11:0]};
		alt  = (f3 == isa_pkg::F3_SRL_SRA) && (imm[11:5] == isa_pkg::F7_ALT);
		send(word, rd, ref_result(f3, alt, model[rs1], b));
	endtask

	// Valid word that must not write anything
	task automatic issue_raw(input logic [31:0] word);
		instr_valid_i = 1'b1;
		instr_i       = word;
		tick();
	endtask

	task automatic idle(input int n);
		instr_valid_i = 1'b0;
		instr_i       = '0;
		repeat (n) tick();
	endtask

	task automatic drain();
		instr_valid_i = 1'b0;
		instr_i       = '0;
		for (int n = 0; n < 16 && exp_cycle.size() > 0; n++)
			tick();
		if (exp_cycle.size() > 0)
		begin
			$display("Timed out waiting for write-back to x%0d", exp_addr[0]);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	endtask

	task automatic test_reset();
		for (int i = 0; i < 4; i++)
		begin
			idle(1);
			check({27'b0, wb_addr_o}, 32'd0, "wb_addr_o after reset");
			check(wb_data_o, 32'd0, "wb_data_o after reset");
		end
	endtask

	task automatic test_arith_logic();
		for (int r = 1; r <= 6; r++)
			issue_i(rand_bits(12), 0, isa_pkg::F3_ADD_SUB, r);
		drain();
		issue_r(7'b0, 2, 1, isa_pkg::F3_ADD_SUB, 7);
		drain();
		issue_r(isa_pkg::F7_ALT, 4, 3, isa_pkg::F3_ADD_SUB, 8);
		drain();
		issue_r(7'b0, 6, 5, isa_pkg::F3_AND, 9);
		issue_r(7'b0, 1, 7, isa_pkg::F3_OR, 10);
		issue_r(7'b0, 8, 2, isa_pkg::F3_XOR, 11);
		drain();
		issue_i(rand_bits(12), 7, isa_pkg::F3_ADD_SUB, 12);
		issue_i(rand_bits(12), 8, isa_pkg::F3_AND, 13);
		issue_i(rand_bits(12), 9, isa_pkg::F3_OR, 14);
		issue_i(rand_bits(12), 10, isa_pkg::F3_XOR, 15);
		drain();
	endtask

	task automatic test_shifts();
		logic [31:0] amt;
		// Negative operand so SRA and SRAI must fill with ones
		issue_i({20'b0, 1'b1, rand_bits(11)}, 0, isa_pkg::F3_ADD_SUB, 8);
		drain();
		for (int k = 0; k < 4; k++)
		begin
			amt = rand_bits(5);
			issue_i(amt, 8, isa_pkg::F3_SLL, 21);
			issue_i(amt, 8, isa_pkg::F3_SRL_SRA, 22);
			issue_i({20'b0, isa_pkg::F7_ALT, amt[4:0]}, 8, isa_pkg::F3_SRL_SRA, 23);
			issue_i(rand_bits(11), 0, isa_pkg::F3_ADD_SUB, 9);
			issue_r(7'b0, 9, 8, isa_pkg::F3_SLL, 24);
			issue_r(7'b0, 9, 8, isa_pkg::F3_SRL_SRA, 25);
			issue_r(isa_pkg::F7_ALT, 9, 8, isa_pkg::F3_SRL_SRA, 26);
			drain();
		end
	endtask

	task automatic test_compare();
		issue_i({20'b0, 1'b1, rand_bits(11)}, 0, isa_pkg::F3_ADD_SUB, 10);
		issue_i({20'b0, 1'b0, rand_bits(11)}, 0, isa_pkg::F3_ADD_SUB, 11);
		drain();
		issue_r(7'b0, 11, 10, isa_pkg::F3_SLT, 12);
		issue_r(7'b0, 11, 10, isa_pkg::F3_SLTU, 13);
		issue_r(7'b0, 10, 11, isa_pkg::F3_SLT, 14);
		issue_r(7'b0, 10, 11, isa_pkg::F3_SLTU, 15);
		issue_i({20'b0, 1'b0, rand_bits(11)}, 10, isa_pkg::F3_SLT, 16);
		issue_i({20'b0, 1'b0, rand_bits(11)}, 10, isa_pkg::F3_SLTU, 17);
		drain();
	endtask

	task automatic test_forwarding();
		issue_i(rand_bits(12), 0, isa_pkg::F3_ADD_SUB, 13);
		issue_r(7'b0, 13, 13, isa_pkg::F3_ADD_SUB, 14);
		issue_r(7'b0, 13, 14, isa_pkg::F3_ADD_SUB, 15);
		idle(1);
		issue_r(isa_pkg::F7_ALT, 14, 15, isa_pkg::F3_ADD_SUB, 16);
		issue_r(7'b0, 15, 16, isa_pkg::F3_XOR, 13);
		idle(1);
		issue_r(7'b0, 13, 16, isa_pkg::F3_OR, 17);
		issue_i(rand_bits(12), 17, isa_pkg::F3_AND, 17);
		drain();
	endtask

	task automatic test_no_write();
		issue_r(7'b0, 2, 1, isa_pkg::F3_ADD_SUB, 0);
		issue_i(rand_bits(12), 1, isa_pkg::F3_ADD_SUB, 0);
		// LUI and LW encodings are outside the core
		issue_raw({20'h12345, 5'd5, 7'b0110111});
		issue_raw({12'h004, 5'd1, 3'b010, 5'd6, 7'b0000011});
		instr_valid_i = 1'b0;
		instr_i       = {7'b0, 5'd2, 5'd1, isa_pkg::F3_ADD_SUB, 5'd5, isa_pkg::OPC_OP};
		tick();
		idle(4);
		issue_r(7'b0, 0, 0, isa_pkg::F3_ADD_SUB, 18);
		issue_r(7'b0, 0, 5, isa_pkg::F3_OR, 19);
		issue_i(32'd0, 6, isa_pkg::F3_ADD_SUB, 20);
		drain();
	endtask

	initial
	begin
		clk           = 1'b0;
		rst           = 1'b1;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		lfsr_state    = 32'h136;
		cyc           = 0;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		test_reset();
		test_arith_logic();
		test_shifts();
		test_compare();
		test_forwarding();
		test_no_write();
		$display("All checks passed");
		$finish;
	end

endmodule
